// File: logic/tetris_pkg.sv
package tetris_pkg;

        ////////////////////
        // frame geometry
        ////////////////////

        // playfield size in cells
        localparam int FRAME_ROWS = 5;
        localparam int FRAME_COLS = 5;

        // colour per cell, zero is empty
        localparam int COLOR_W = 3;

        // signed coordinate, wide enough for targets just off the frame
        localparam int COORD_W = 4;

        // cells per piece, also the probe count
        localparam int PIECE_CELLS = 4;

        // flattened frame, cell (r,c) at lsb (r*FRAME_COLS+c)*COLOR_W
        localparam int FRAME_W = FRAME_ROWS * FRAME_COLS * COLOR_W;

        ////////////////////
        // enums
        ////////////////////

        // request opcodes
        typedef enum logic [2:0] {
                OP_SPAWN,
                OP_LEFT,
                OP_RIGHT,
                OP_DOWN,
                OP_ROR,
                OP_ROL
        } op_t;

        // spawn shapes
        typedef enum logic [2:0] {
                SHAPE_I,
                SHAPE_O,
                SHAPE_T,
                SHAPE_S,
                SHAPE_Z,
                SHAPE_L,
                SHAPE_J
        } shape_t;

        // updater FSM
        typedef enum logic [1:0] {
                ST_IDLE,
                ST_PROBE,
                ST_COMMIT
        } track_state_t;

endpackage

// File: logic/move_planner.sv
module move_planner import tetris_pkg::*; (
        input  logic                                 clk_i,
        input  logic                                 arst_n_i,
        input  logic                                 req_i,
        input  op_t                                  op_i,
        input  shape_t                               shape_i,
        input  logic [COLOR_W-1:0]                   color_i,
        input  logic                                 busy_i,
        input  logic [PIECE_CELLS-1:0][COORD_W-1:0]  cur_row_i,
        input  logic [PIECE_CELLS-1:0][COORD_W-1:0]  cur_col_i,
        output logic                                 plan_valid_o,
        output op_t                                  plan_op_o,
        output logic [COLOR_W-1:0]                   plan_color_o,
        output logic [PIECE_CELLS-1:0][COORD_W-1:0]  tgt_row_o,
        output logic [PIECE_CELLS-1:0][COORD_W-1:0]  tgt_col_o
);

        // request taken only while idle
        logic accept;
        // one cycle after accept, targets are being computed
        logic pend;
        shape_t shape_q;

        // spawn table, one nibble per cell as {row bit, col[2:0]}
        logic [4*PIECE_CELLS-1:0] spawn_code;

        logic [PIECE_CELLS-1:0][COORD_W-1:0] nxt_row;
        logic [PIECE_CELLS-1:0][COORD_W-1:0] nxt_col;

        // cell 1 is the rotation pivot
        logic signed [COORD_W-1:0] piv_row;
        logic signed [COORD_W-1:0] piv_col;

        assign accept  = req_i && !busy_i;
        assign piv_row = $signed(cur_row_i[1]);
        assign piv_col = $signed(cur_col_i[1]);

        ////////////////////
        // request latch
        ////////////////////

        always_ff @(posedge clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        pend         <= 1'b0;
                        plan_valid_o <= 1'b0;
                end else begin
                        pend         <= accept;
                        plan_valid_o <= pend;
                end
        end

        // request payload held until the next accept
        always_ff @(posedge clk_i) begin
                if (accept) begin
                        plan_op_o    <= op_i;
                        shape_q      <= shape_i;
                        plan_color_o <= color_i;
                end
        end

        ////////////////////
        // spawn table
        ////////////////////

        // rows 0 and 1, leftmost cell in column 1
        always_comb begin
                case (shape_q)
                        SHAPE_I: spawn_code = 16'h4321;
                        SHAPE_O: spawn_code = 16'hA921;
                        SHAPE_T: spawn_code = 16'hA321;
                        SHAPE_S: spawn_code = 16'h32A9;
                        SHAPE_Z: spawn_code = 16'hBA21;
                        SHAPE_L: spawn_code = 16'h9321;
                        default: spawn_code = 16'hB321;
                endcase
        end

        ////////////////////
        // target math
        ////////////////////

        always_comb begin
                logic signed [COORD_W-1:0] d_row;
                logic signed [COORD_W-1:0] d_col;
                for (int i = 0; i < PIECE_CELLS; i++) begin
                        // offset from pivot
                        d_row      = $signed(cur_row_i[i]) - piv_row;
                        d_col      = $signed(cur_col_i[i]) - piv_col;
                        nxt_row[i] = cur_row_i[i];
                        nxt_col[i] = cur_col_i[i];
                        case (plan_op_o)
                                OP_SPAWN: begin
                                        nxt_row[i] = {{(COORD_W-1){1'b0}}, spawn_code[4*i+3]};
                                        nxt_col[i] = {{(COORD_W-3){1'b0}}, spawn_code[4*i +: 3]};
                                end
                                OP_LEFT: nxt_col[i] = cur_col_i[i] - 1'b1;
                                OP_RIGHT: nxt_col[i] = cur_col_i[i] + 1'b1;
                                OP_DOWN: nxt_row[i] = cur_row_i[i] + 1'b1;
                                // clockwise, row takes col offset
                                OP_ROR: begin
                                        nxt_row[i] = piv_row + d_col;
                                        nxt_col[i] = piv_col - d_row;
                                end
                                // counter-clockwise mirror
                                OP_ROL: begin
                                        nxt_row[i] = piv_row - d_col;
                                        nxt_col[i] = piv_col + d_row;
                                end
                                default: begin
                                        nxt_row[i] = cur_row_i[i];
                                        nxt_col[i] = cur_col_i[i];
                                end
                        endcase
                end
        end

        // targets registered one edge after accept
        always_ff @(posedge clk_i) begin
                if (pend) begin
                        tgt_row_o <= nxt_row;
                        tgt_col_o <= nxt_col;
                end
        end

endmodule

// File: logic/cell_probe.sv
module cell_probe import tetris_pkg::*; (
        input  logic                                 clk_i,
        input  logic                                 arst_n_i,
        input  logic                                 plan_valid_i,
        input  logic                                 spawn_i,
        input  logic [COORD_W-1:0]                   tgt_row_i,
        input  logic [COORD_W-1:0]                   tgt_col_i,
        input  logic [FRAME_W-1:0]                   frame_i,
        input  logic [PIECE_CELLS-1:0][COORD_W-1:0]  own_row_i,
        input  logic [PIECE_CELLS-1:0][COORD_W-1:0]  own_col_i,
        output logic                                 free_o,
        output logic                                 probe_valid_o
);

        logic in_bounds;
        logic own_hit;
        logic cell_free;
        logic [COLOR_W-1:0] cell_color;

        // negative coordinates wrap high, so compare signed
        assign in_bounds = ($signed(tgt_row_i) >= 0) && ($signed(tgt_row_i) < FRAME_ROWS) &&
                           ($signed(tgt_col_i) >= 0) && ($signed(tgt_col_i) < FRAME_COLS);

        // colour under the target, only read inside the frame
        always_comb begin
                cell_color = '0;
                if (in_bounds) begin
                        cell_color = frame_i[(tgt_row_i * FRAME_COLS + tgt_col_i) * COLOR_W +: COLOR_W];
                end
        end

        // target sits on a cell the piece already holds
        always_comb begin
                own_hit = 1'b0;
                for (int k = 0; k < PIECE_CELLS; k++) begin
                        own_hit = own_hit || ((tgt_row_i == own_row_i[k]) &&
                                              (tgt_col_i == own_col_i[k]));
                end
                // a new piece owns nothing
                if (spawn_i) begin
                        own_hit = 1'b0;
                end
        end

        assign cell_free = in_bounds && ((cell_color == '0) || own_hit);

        ////////////////////
        // result register
        ////////////////////

        always_ff @(posedge clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        free_o        <= 1'b0;
                        probe_valid_o <= 1'b0;
                end else begin
                        probe_valid_o <= plan_valid_i;
                        if (plan_valid_i) begin
                                free_o <= cell_free;
                        end
                end
        end

endmodule

// File: logic/frame_updater.sv
module frame_updater import tetris_pkg::*; (
        input  logic                                 clk_i,
        input  logic                                 arst_n_i,
        input  logic                                 req_set_i,
        input  logic [PIECE_CELLS-1:0]               probe_valid_i,
        input  logic [PIECE_CELLS-1:0]               free_i,
        input  op_t                                  plan_op_i,
        input  logic [COLOR_W-1:0]                   plan_color_i,
        input  logic [PIECE_CELLS-1:0][COORD_W-1:0]  tgt_row_i,
        input  logic [PIECE_CELLS-1:0][COORD_W-1:0]  tgt_col_i,
        output logic [FRAME_W-1:0]                   frame_o,
        output logic [PIECE_CELLS-1:0][COORD_W-1:0]  cur_row_o,
        output logic [PIECE_CELLS-1:0][COORD_W-1:0]  cur_col_o,
        output logic                                 active_o,
        output logic                                 done_o,
        output logic                                 moved_o,
        output logic                                 busy_o
);

        track_state_t state;

        // colour of the live piece
        logic [COLOR_W-1:0] piece_color;
        logic [COLOR_W-1:0] paint_color;
        logic spawn;
        logic commit;
        logic move_ok;
        logic [FRAME_W-1:0] frame_nxt;

        assign spawn       = (plan_op_i == OP_SPAWN);
        // all four probes report on the same edge
        assign commit      = (state == ST_PROBE) && (&probe_valid_i);
        // a move needs a live piece
        assign move_ok     = (&free_i) && (spawn || active_o);
        assign paint_color = spawn ? plan_color_i : piece_color;

        assign busy_o = (state == ST_PROBE);
        assign done_o = (state == ST_COMMIT);

        ////////////////////
        // next frame
        ////////////////////

        always_comb begin
                frame_nxt = frame_o;
                if (move_ok) begin
                        // old cells first, a spawn leaves the previous piece
                        if (!spawn) begin
                                for (int k = 0; k < PIECE_CELLS; k++) begin
                                        frame_nxt[(cur_row_o[k] * FRAME_COLS + cur_col_o[k]) *
                                                  COLOR_W +: COLOR_W] = '0;
                                end
                        end
                        // then paint targets, all in bounds here
                        for (int k = 0; k < PIECE_CELLS; k++) begin
                                frame_nxt[(tgt_row_i[k] * FRAME_COLS + tgt_col_i[k]) *
                                          COLOR_W +: COLOR_W] = paint_color;
                        end
                end
        end

        ////////////////////
        // FSM and state
        ////////////////////

        always_ff @(posedge clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                        state     <= ST_IDLE;
                        frame_o   <= '0;
                        cur_row_o <= '0;
                        cur_col_o <= '0;
                        active_o  <= 1'b0;
                        moved_o   <= 1'b0;
                end else begin
                        case (state)
                                ST_IDLE: begin
                                        if (req_set_i) begin
                                                state <= ST_PROBE;
                                        end
                                end
                                // wait out planner and probes
                                ST_PROBE: begin
                                        if (commit) begin
                                                state   <= ST_COMMIT;
                                                moved_o <= move_ok;
                                                if (move_ok) begin
                                                        frame_o   <= frame_nxt;
                                                        cur_row_o <= tgt_row_i;
                                                        cur_col_o <= tgt_col_i;
                                                        if (spawn) begin
                                                                active_o <= 1'b1;
                                                        end
                                                end
                                        end
                                end
                                // done cycle, next request may start here
                                ST_COMMIT: begin
                                        state <= req_set_i ? ST_PROBE : ST_IDLE;
                                end
                                default: state <= ST_IDLE;
                        endcase
                end
        end

        // piece colour taken from a successful spawn
        always_ff @(posedge clk_i) begin
                if (commit && move_ok && spawn) begin
                        piece_color <= plan_color_i;
                end
        end

endmodule

// File: logic/tracker_top.sv
module tracker_top import tetris_pkg::*; (
        input  logic                clk_i,
        input  logic                arst_n_i,
        input  logic                req_i,
        input  op_t                 op_i,
        input  shape_t              shape_i,
        input  logic [COLOR_W-1:0]  color_i,
        output logic                busy_o,
        output logic                done_o,
        output logic                moved_o,
        output logic                active_o,
        output logic [FRAME_W-1:0]  frame_o
);

        // planner outputs
        logic plan_valid;
        op_t plan_op;
        logic plan_spawn;
        logic [COLOR_W-1:0] plan_color;
        logic [PIECE_CELLS-1:0][COORD_W-1:0] tgt_row;
        logic [PIECE_CELLS-1:0][COORD_W-1:0] tgt_col;

        // updater piece cells, fed back as own cells
        logic [PIECE_CELLS-1:0][COORD_W-1:0] cur_row;
        logic [PIECE_CELLS-1:0][COORD_W-1:0] cur_col;

        // probe results
        logic [PIECE_CELLS-1:0] free;
        logic [PIECE_CELLS-1:0] probe_valid;

        assign plan_spawn = (plan_op == OP_SPAWN);

        ////////////////////
        // stage 1
        ////////////////////

        move_planner move_planner_inst (
                .clk_i        (clk_i),
                .arst_n_i     (arst_n_i),
                .req_i        (req_i),
                .op_i         (op_i),
                .shape_i      (shape_i),
                .color_i      (color_i),
                .busy_i       (busy_o),
                .cur_row_i    (cur_row),
                .cur_col_i    (cur_col),
                .plan_valid_o (plan_valid),
                .plan_op_o    (plan_op),
                .plan_color_o (plan_color),
                .tgt_row_o    (tgt_row),
                .tgt_col_o    (tgt_col)
        );

        ////////////////////
        // stage 2
        ////////////////////

        // one probe per piece cell
        for (genvar i = 0; i < PIECE_CELLS; i++) begin : probe_gen
                cell_probe cell_probe_inst (
                        .clk_i         (clk_i),
                        .arst_n_i      (arst_n_i),
                        .plan_valid_i  (plan_valid),
                        .spawn_i       (plan_spawn),
                        .tgt_row_i     (tgt_row[i]),
                        .tgt_col_i     (tgt_col[i]),
                        .frame_i       (frame_o),
                        .own_row_i     (cur_row),
                        .own_col_i     (cur_col),
                        .free_o        (free[i]),
                        .probe_valid_o (probe_valid[i])
                );
        end

        ////////////////////
        // stage 3
        ////////////////////

        frame_updater frame_updater_inst (
                .clk_i         (clk_i),
                .arst_n_i      (arst_n_i),
                .req_set_i     (req_i),
                .probe_valid_i (probe_valid),
                .free_i        (free),
                .plan_op_i     (plan_op),
                .plan_color_i  (plan_color),
                .tgt_row_i     (tgt_row),
                .tgt_col_i     (tgt_col),
                .frame_o       (frame_o),
                .cur_row_o     (cur_row),
                .cur_col_o     (cur_col),
                .active_o      (active_o),
                .done_o        (done_o),
                .moved_o       (moved_o),
                .busy_o        (busy_o)
        );

endmodule

// File: bench/clock_gen.sv
module clock_gen (
        output logic clk_o
);

        ////////////////////
        // free running clock
        ////////////////////

        // period 100, low for the first half
        initial begin
                clk_o = 1'b0;
                forever begin
                        #50 clk_o = ~clk_o;
                end
        end

endmodule

// File: bench/tracker_tb.sv
module tracker_tb import tetris_pkg::*; ();

        // DUT side signals
        logic clk;
        logic arst_n;
        logic req;
        op_t op;
        shape_t shape;
        logic [COLOR_W-1:0] color;
        logic busy;
        logic done;
        logic moved;
        logic active;
        logic [FRAME_W-1:0] frame;

        // steps from the golden file, one entry per line
        string step_name[$];
        logic [2:0] step_op[$];
        logic [2:0] step_shape[$];
        logic [COLOR_W-1:0] step_color[$];
        logic step_dup[$];
        logic step_moved[$];
        logic step_active[$];
        logic [FRAME_W-1:0] step_frame[$];

        int pass_count = 0;
        int fail_count = 0;
        int cycle_count = 0;
        int cycle_limit = 50;
        logic load_ok = 1'b0;
        logic test_ok = 1'b1;

        clock_gen clock_gen_inst (
                .clk_o (clk)
        );

        tracker_top tracker_top_inst (
                .clk_i    (clk),
                .arst_n_i (arst_n),
                .req_i    (req),
                .op_i     (op),
                .shape_i  (shape),
                .color_i  (color),
                .busy_o   (busy),
                .done_o   (done),
                .moved_o  (moved),
                .active_o (active),
                .frame_o  (frame)
        );

        ////////////////////
        // helpers
        ////////////////////

        // one compare for every checked value
        task automatic check_value(input string test, input string what,
                                   input logic [FRAME_W-1:0] expected,
                                   input logic [FRAME_W-1:0] actual);
                if (actual !== expected) begin
                        $display("[ERROR] %s %s: expected %0h, actual %0h",
                                 test, what, expected, actual);
                        test_ok = 1'b0;
                end
        endtask

        // lines starting with # are column notes
        task automatic load_golden();
                int fd;
                int code;
                int ch;
                string tok;
                logic [2:0] f_op;
                logic [2:0] f_shape;
                logic [COLOR_W-1:0] f_color;
                logic f_dup;
                logic f_moved;
                logic f_active;
                logic [FRAME_W-1:0] f_frame;
                fd = $fopen("bench/tracker_golden.txt", "r");
                if (fd == 0) begin
                        $display("could not open bench/tracker_golden.txt");
                end else begin
                        load_ok = 1'b1;
                        code = $fscanf(fd, "%s", tok);
                        while (code == 1) begin
                                if (tok[0] == "#") begin
                                        // drop the rest of the note
                                        ch = $fgetc(fd);
                                        while (ch != 10 && ch != -1) begin
                                                ch = $fgetc(fd);
                                        end
                                end else begin
                                        code = $fscanf(fd, "%h %h %h %h %h %h %h", f_op,
                                                       f_shape, f_color, f_dup, f_moved,
                                                       f_active, f_frame);
                                        if (code != 7) begin
                                                $display("golden line for %s is malformed", tok);
                                                load_ok = 1'b0;
                                        end else begin
                                                step_name.push_back(tok);
                                                step_op.push_back(f_op);
                                                step_shape.push_back(f_shape);
                                                step_color.push_back(f_color);
                                                step_dup.push_back(f_dup);
                                                step_moved.push_back(f_moved);
                                                step_active.push_back(f_active);
                                                step_frame.push_back(f_frame);
                                        end
                                end
                                code = $fscanf(fd, "%s", tok);
                        end
                        $fclose(fd);
                        if (step_name.size() == 0) begin
                                $display("golden file holds no steps");
                                load_ok = 1'b0;
                        end
                end
        endtask

        // tally one finished test and print its line
        task automatic report_test(input string test);
                if (test_ok) begin
                        pass_count++;
                        $display("%s: pass", test);
                end else begin
                        fail_count++;
                        $display("%s: FAIL", test);
                end
        endtask

        ////////////////////
        // one request
        ////////////////////

        task automatic run_step(input int idx);
                int lat;
                logic seen;
                string name;
                name = step_name[idx];
                test_ok = 1'b1;
                @(posedge clk);
                #10;
                req = 1'b1;
                op = op_t'(step_op[idx]);
                shape = shape_t'(step_shape[idx]);
                color = step_color[idx];
                // accepting edge
                @(posedge clk);
                #10;
                check_value(name, "busy_o after accept", 1, busy);
                // second strobe while busy, must be dropped
                if (step_dup[idx]) begin
                        op = OP_DOWN;
                        @(posedge clk);
                        #10;
                end
                req = 1'b0;
                lat = step_dup[idx] ? 1 : 0;
                seen = 1'b0;
                // sample on the falling edge, outputs settled
                while (!seen && lat < 4) begin
                        @(negedge clk);
                        if (done) begin
                                seen = 1'b1;
                        end else begin
                                lat++;
                        end
                end
                if (!seen) begin
                        $display("%s: done_o did not arrive within 4 cycles of the request", name);
                        test_ok = 1'b0;
                end else begin
                        check_value(name, "done latency", 3, lat);
                        check_value(name, "busy_o with done", 0, busy);
                        check_value(name, "moved_o", step_moved[idx], moved);
                        check_value(name, "active_o", step_active[idx], active);
                        check_value(name, "frame_o", step_frame[idx], frame);
                        // single pulse, nothing left in flight
                        repeat (2) begin
                                @(negedge clk);
                                check_value(name, "done_o after pulse", 0, done);
                        end
                end
                report_test(name);
        endtask

        ////////////////////
        // watchdog
        ////////////////////

        always @(posedge clk) begin
                cycle_count++;
                if (cycle_count >= cycle_limit) begin
                        $display("timeout: run exceeded %0d cycles", cycle_limit);
                        $display("Simulation failed");
                        $finish;
                end
        end

        ////////////////////
        // main sequence
        ////////////////////

        initial begin
                arst_n = 1'b0;
                req = 1'b0;
                op = OP_SPAWN;
                shape = SHAPE_I;
                color = '0;
                load_golden();
                // 8 cycles per step plus reset and margin
                cycle_limit = 8 * step_name.size() + 50;
                repeat (3) @(posedge clk);
                #10;
                arst_n = 1'b1;
                @(negedge clk);
                test_ok = 1'b1;
                check_value("reset_state", "busy_o", 0, busy);
                check_value("reset_state", "done_o", 0, done);
                check_value("reset_state", "moved_o", 0, moved);
                check_value("reset_state", "active_o", 0, active);
                check_value("reset_state", "frame_o", 0, frame);
                report_test("reset_state");
                if (load_ok) begin
                        for (int i = 0; i < step_name.size(); i++) begin
                                run_step(i);
                        end
                end
                $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
                if (load_ok && fail_count == 0) begin
                        $display("Simulation passed");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

endmodule

// File: bench/tracker_golden.txt
# name op shape color dup moved active frame, all but name in hex
# op 0 spawn 1 left 2 right 3 down 4 ror 5 rol, frame cell (r,c) at bit 3*(5r+c)
move_idle 3 0 0 0 0 0 0000000000000000000
spawn_t 0 2 5 0 1 1 0000000000000A00B68
spawn_overlap 0 1 3 0 0 1 0000000000000A00B68
left_own 1 0 0 0 1 1 000000000000014016D
left_edge 1 0 0 0 0 1 000000000000014016D
right_busy 2 0 0 1 1 1 0000000000000A00B68
right_2 2 0 0 0 1 1 0000000000005005B40
right_edge 2 0 0 0 0 1 0000000000005005B40
ror_bounds 4 0 0 0 0 1 0000000000005005B40
down_1 3 0 0 0 1 1 000000002802DA00000
ror_1 4 0 0 0 1 1 0000000028005A00A00
rol_1 5 0 0 0 1 1 000000002802DA00000
down_2 3 0 0 1 1 1 000014016D000000000
down_3 3 0 0 0 1 1 0A00B68000000000000
down_floor 3 0 0 0 0 1 0A00B68000000000000
spawn_i 0 0 6 0 1 1 0A00B68000000006DB0
down_i1 3 0 0 0 1 1 0A00B68000036D80000
down_i2 3 0 0 0 1 1 0A00B681B6C00000000
down_blocked 3 0 0 0 0 1 0A00B681B6C00000000
rol_blocked 5 0 0 0 0 1 0A00B681B6C00000000
left_i 1 0 0 0 1 1 0A00B68036D80000000
ror_i_busy 4 0 0 1 1 1 0A30B6E000C00180000
down_i_floor 3 0 0 0 0 1 0A30B6E000C00180000

// File: sources.f
logic/tetris_pkg.sv
logic/move_planner.sv
logic/cell_probe.sv
logic/frame_updater.sv
logic/tracker_top.sv
bench/clock_gen.sv
bench/tracker_tb.sv

// File: Bender.yml
package:
  name: tracker

sources:
  - logic/tetris_pkg.sv
  - logic/move_planner.sv
  - logic/cell_probe.sv
  - logic/frame_updater.sv
  - logic/tracker_top.sv
  - target: simulation
    files:
      - bench/clock_gen.sv
      - bench/tracker_tb.sv
